//--- hw/soc_pkg.sv
// Shared bus widths, address map, CLINT register offsets and
// the target select encoding for the memory-mapped bus
package soc_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    typedef logic [31:0] addr_t;   // Byte address
    typedef logic [31:0] data_t;   // Bus word
    typedef logic [3:0]  strb_t;   // One bit per byte lane
    typedef logic [63:0] timer_t;  // mtime and mtimecmp

    // Which target a request goes to
    typedef enum logic [1:0] {
        SEL_ROM   = 2'd0,
        SEL_CLINT = 2'd1,
        SEL_RAM   = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // --------------------------------------------------
    // Address map
    // --------------------------------------------------
    localparam addr_t RomBase     = 32'h0001_0000;
    localparam int    RomWords    = 16;              // Boot image depth
    localparam addr_t ClintBase   = 32'h0200_0000;
    localparam addr_t ClintLength = 32'h0000_C000;
    localparam addr_t RamBase     = 32'h8000_0000;   // Length set by RamWords

    // CLINT register offsets, byte addressed
    localparam addr_t ClintMsipOffset  = 32'h0000_0000;
    localparam addr_t MtimecmpLoOffset = 32'h0000_4000;
    localparam addr_t MtimecmpHiOffset = 32'h0000_4004;
    localparam addr_t MtimeLoOffset    = 32'h0000_BFF8;
    localparam addr_t MtimeHiOffset    = 32'h0000_BFFC;

endpackage

//--- hw/soc_req_decode.sv
// Request side of the bus: address decode, error marking and the
// decode and select register stages
`timescale 1ns/1ps

module soc_req_decode #(
    parameter int RamWords = 4096
) (
    input  logic                clk,
    input  logic                ndmreset_n,
    input  logic                req_valid_i,
    input  logic                req_we_i,
    input  soc_pkg::addr_t      req_addr_i,
    input  soc_pkg::data_t      req_wdata_i,
    input  soc_pkg::strb_t      req_strb_i,
    input  logic                pipe_advance_i,
    output logic                req_ready_o,
    output logic                dec_valid_o,
    output soc_pkg::slave_sel_e dec_sel_o,
    output logic                dec_we_o,
    output soc_pkg::addr_t      dec_offset_o,
    output soc_pkg::data_t      dec_wdata_o,
    output soc_pkg::strb_t      dec_strb_o,
    output logic                valid_q_o,
    output logic                we_q_o,
    output soc_pkg::slave_sel_e sel_q_o,
    output logic                err_q_o
);
    localparam soc_pkg::addr_t RomLength = soc_pkg::addr_t'(soc_pkg::RomWords * 4);
    localparam soc_pkg::addr_t RamLength = soc_pkg::addr_t'(RamWords * 4);

    soc_pkg::addr_t      rom_off;
    soc_pkg::addr_t      clint_off;
    soc_pkg::addr_t      ram_off;
    soc_pkg::addr_t      req_off;
    soc_pkg::slave_sel_e req_sel;
    logic                req_err;
    logic                dec_err_q;

    assign req_ready_o = pipe_advance_i;

    // Unsigned wrap makes one compare cover both region bounds
    assign rom_off   = req_addr_i - soc_pkg::RomBase;
    assign clint_off = req_addr_i - soc_pkg::ClintBase;
    assign ram_off   = req_addr_i - soc_pkg::RamBase;

    always_comb begin
        req_sel = soc_pkg::SEL_NONE;
        req_off = '0;
        req_err = 1'b1;
        if (rom_off < RomLength) begin
            req_off = rom_off;
            if (!req_we_i) begin         // ROM is read only
                req_sel = soc_pkg::SEL_ROM;
                req_err = 1'b0;
            end
        end else if (clint_off < soc_pkg::ClintLength) begin
            req_sel = soc_pkg::SEL_CLINT;
            req_off = clint_off;
            req_err = 1'b0;
        end else if (ram_off < RamLength) begin
            req_sel = soc_pkg::SEL_RAM;
            req_off = ram_off;
            req_err = 1'b0;
        end
    end

    // --------------------------------------------------
    // Decode stage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            dec_valid_o <= 1'b0;
            dec_sel_o   <= soc_pkg::SEL_NONE;
            dec_we_o    <= 1'b0;
            dec_err_q   <= 1'b0;
        end else if (pipe_advance_i) begin
            dec_valid_o <= req_valid_i;
            dec_sel_o   <= req_valid_i ? req_sel : soc_pkg::SEL_NONE;
            dec_we_o    <= req_we_i;
            dec_err_q   <= req_err;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_advance_i && req_valid_i) begin
            dec_offset_o <= req_off;
            dec_wdata_o  <= req_wdata_i;
            dec_strb_o   <= req_strb_i;
        end
    end

    // --------------------------------------------------
    // Select stage, runs beside the target read
    // --------------------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            valid_q_o <= 1'b0;
            we_q_o    <= 1'b0;
            sel_q_o   <= soc_pkg::SEL_NONE;
            err_q_o   <= 1'b0;
        end else if (pipe_advance_i) begin
            valid_q_o <= dec_valid_o;
            we_q_o    <= dec_we_o;
            sel_q_o   <= dec_sel_o;
            err_q_o   <= dec_err_q;
        end
    end

endmodule

//--- hw/boot_rom.sv
// Boot ROM loaded from a hex image, registered read
`timescale 1ns/1ps

module boot_rom (
    input  logic           clk,
    input  logic           req_i,
    input  soc_pkg::addr_t word_idx_i,
    input  logic           en_i,
    output soc_pkg::data_t rdata_o
);
    localparam int    IdxBits = $clog2(soc_pkg::RomWords);
    localparam string RomFile = "hw/boot_rom.hex";

    soc_pkg::data_t     rom_mem [soc_pkg::RomWords];
    logic [IdxBits-1:0] idx;

    // Image fixed at elaboration
    initial begin
        $readmemh(RomFile, rom_mem);
    end

    assign idx = word_idx_i[IdxBits-1:0];   // Region check done in decode

    always_ff @(posedge clk) begin
        if (req_i && en_i) begin
            rdata_o <= rom_mem[idx];
        end
    end

endmodule

//--- hw/clint_timer.sv
// Core-local interruptor with real-time tick, mtime, mtimecmp,
// msip and the register read port
`timescale 1ns/1ps

module clint_timer (
    input  logic           clk,
    input  logic           ndmreset_n,
    input  logic           req_i,
    input  logic           we_i,
    input  soc_pkg::addr_t offset_i,
    input  soc_pkg::data_t wdata_i,
    input  logic           en_i,
    output soc_pkg::data_t rdata_o,
    output logic           timer_irq_o,
    output logic           ipi_o
);
    logic              rtc;
    logic              msip_q;
    logic              wr_en;
    soc_pkg::timer_t   mtime_q;
    soc_pkg::timer_t   mtimecmp_q;

    // --------------------------------------------------
    // Real-time tick, clk divided by two
    // --------------------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc <= 1'b0;
        end else begin
            rtc <= ~rtc;
        end
    end

    assign wr_en = req_i & we_i & en_i;   // Whole word writes, strobes ignored

    // --------------------------------------------------
    // Timer and interrupt registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q     <= '0;
            mtimecmp_q  <= '1;          // No interrupt until programmed
            msip_q      <= 1'b0;
            timer_irq_o <= 1'b0;
        end else begin
            if (rtc) begin               // One count per tick period
                mtime_q <= mtime_q + 1'b1;
            end
            if (wr_en) begin
                case (offset_i)
                    soc_pkg::ClintMsipOffset:  msip_q <= wdata_i[0];
                    soc_pkg::MtimecmpLoOffset: mtimecmp_q[31:0] <= wdata_i;
                    soc_pkg::MtimecmpHiOffset: mtimecmp_q[63:32] <= wdata_i;
                    soc_pkg::MtimeLoOffset:    mtime_q <= {mtime_q[63:32], wdata_i};
                    soc_pkg::MtimeHiOffset:    mtime_q <= {wdata_i, mtime_q[31:0]};
                    default: ;
                endcase
            end
            timer_irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

    assign ipi_o = msip_q;

    // Register read, unknown offsets read as zero
    always_ff @(posedge clk) begin
        if (req_i && en_i) begin
            case (offset_i)
                soc_pkg::ClintMsipOffset:  rdata_o <= {31'b0, msip_q};
                soc_pkg::MtimecmpLoOffset: rdata_o <= mtimecmp_q[31:0];
                soc_pkg::MtimecmpHiOffset: rdata_o <= mtimecmp_q[63:32];
                soc_pkg::MtimeLoOffset:    rdata_o <= mtime_q[31:0];
                soc_pkg::MtimeHiOffset:    rdata_o <= mtime_q[63:32];
                default:                   rdata_o <= '0;
            endcase
        end
    end

endmodule

//--- hw/scratch_ram.sv
// Scratch RAM with byte strobes and registered read
`timescale 1ns/1ps

module scratch_ram #(
    parameter int RamWords = 4096
) (
    input  logic           clk,
    input  logic           req_i,
    input  logic           we_i,
    input  soc_pkg::addr_t word_idx_i,
    input  soc_pkg::data_t wdata_i,
    input  soc_pkg::strb_t strb_i,
    input  logic           en_i,
    output soc_pkg::data_t rdata_o
);
    localparam int IdxBits  = $clog2(RamWords);
    localparam int NumBytes = $bits(soc_pkg::strb_t);

    soc_pkg::data_t     ram_mem [RamWords];
    logic [IdxBits-1:0] idx;

    assign idx = word_idx_i[IdxBits-1:0];

    // A write also reads back the old word
    always_ff @(posedge clk) begin
        if (req_i && en_i) begin
            rdata_o <= ram_mem[idx];
            if (we_i) begin
                for (int b = 0; b < NumBytes; b++) begin
                    if (strb_i[b]) begin
                        ram_mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];  // Lane b only
                    end
                end
            end
        end
    end

endmodule

//--- hw/soc_resp_mux.sv
// Response side: read data select, response register and the
// pipeline advance that freezes all stages under back-pressure
`timescale 1ns/1ps

module soc_resp_mux (
    input  logic                clk,
    input  logic                ndmreset_n,
    input  soc_pkg::slave_sel_e sel_q_i,
    input  logic                err_q_i,
    input  logic                stage_valid_i,
    input  logic                we_q_i,
    input  soc_pkg::data_t      rom_rdata_i,
    input  soc_pkg::data_t      clint_rdata_i,
    input  soc_pkg::data_t      ram_rdata_i,
    input  logic                rsp_ready_i,
    output logic                rsp_valid_o,
    output soc_pkg::data_t      rsp_rdata_o,
    output logic                rsp_err_o,
    output logic                pipe_advance_o
);
    soc_pkg::data_t sel_rdata;

    always_comb begin
        case (sel_q_i)
            soc_pkg::SEL_ROM:   sel_rdata = rom_rdata_i;
            soc_pkg::SEL_CLINT: sel_rdata = clint_rdata_i;
            soc_pkg::SEL_RAM:   sel_rdata = ram_rdata_i;
            default:            sel_rdata = '0;
        endcase
        if (err_q_i || we_q_i) begin
            sel_rdata = '0;          // Writes and errors carry no data
        end
    end

    // Stall only while a held response is not taken
    assign pipe_advance_o = ~(rsp_valid_o & ~rsp_ready_i);

    // --------------------------------------------------
    // Response register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rsp_valid_o <= 1'b0;
        end else if (pipe_advance_o) begin
            rsp_valid_o <= stage_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_advance_o) begin
            rsp_rdata_o <= sel_rdata;
            rsp_err_o   <= err_q_i;
        end
    end

endmodule

//--- hw/soc_bus_top.sv
// Bus top level: request decode, ROM, CLINT, RAM and response side
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int RamWords = 4096
) (
    input  logic           clk,
    input  logic           ndmreset_n,
    input  logic           req_valid_i,
    output logic           req_ready_o,
    input  logic           req_we_i,
    input  soc_pkg::addr_t req_addr_i,
    input  soc_pkg::data_t req_wdata_i,
    input  soc_pkg::strb_t req_strb_i,
    output logic           rsp_valid_o,
    input  logic           rsp_ready_i,
    output soc_pkg::data_t rsp_rdata_o,
    output logic           rsp_err_o,
    output logic           timer_irq_o,
    output logic           ipi_o
);
    logic                pipe_advance;
    logic                dec_valid;
    soc_pkg::slave_sel_e dec_sel;
    logic                dec_we;
    soc_pkg::addr_t      dec_offset;
    soc_pkg::addr_t      dec_word_idx;
    soc_pkg::data_t      dec_wdata;
    soc_pkg::strb_t      dec_strb;
    logic                valid_q;
    logic                we_q;
    soc_pkg::slave_sel_e sel_q;
    logic                err_q;
    soc_pkg::data_t      rom_rdata;
    soc_pkg::data_t      clint_rdata;
    soc_pkg::data_t      ram_rdata;

    assign dec_word_idx = {2'b00, dec_offset[31:2]};   // Byte offset to word index

    soc_req_decode #(
        .RamWords ( RamWords )
    ) i_req_decode (
        .clk            ( clk          ),
        .ndmreset_n     ( ndmreset_n   ),
        .req_valid_i    ( req_valid_i  ),
        .req_we_i       ( req_we_i     ),
        .req_addr_i     ( req_addr_i   ),
        .req_wdata_i    ( req_wdata_i  ),
        .req_strb_i     ( req_strb_i   ),
        .pipe_advance_i ( pipe_advance ),
        .req_ready_o    ( req_ready_o  ),
        .dec_valid_o    ( dec_valid    ),
        .dec_sel_o      ( dec_sel      ),
        .dec_we_o       ( dec_we       ),
        .dec_offset_o   ( dec_offset   ),
        .dec_wdata_o    ( dec_wdata    ),
        .dec_strb_o     ( dec_strb     ),
        .valid_q_o      ( valid_q      ),
        .we_q_o         ( we_q         ),
        .sel_q_o        ( sel_q        ),
        .err_q_o        ( err_q        )
    );

    boot_rom i_boot_rom (
        .clk        ( clk                                          ),
        .req_i      ( dec_valid && (dec_sel == soc_pkg::SEL_ROM)   ),
        .word_idx_i ( dec_word_idx                                 ),
        .en_i       ( pipe_advance                                 ),
        .rdata_o    ( rom_rdata                                    )
    );

    clint_timer i_clint (
        .clk         ( clk                                          ),
        .ndmreset_n  ( ndmreset_n                                   ),
        .req_i       ( dec_valid && (dec_sel == soc_pkg::SEL_CLINT) ),
        .we_i        ( dec_we                                       ),
        .offset_i    ( dec_offset                                   ),
        .wdata_i     ( dec_wdata                                    ),
        .en_i        ( pipe_advance                                 ),
        .rdata_o     ( clint_rdata                                  ),
        .timer_irq_o ( timer_irq_o                                  ),
        .ipi_o       ( ipi_o                                        )
    );

    scratch_ram #(
        .RamWords ( RamWords )
    ) i_scratch_ram (
        .clk        ( clk                                          ),
        .req_i      ( dec_valid && (dec_sel == soc_pkg::SEL_RAM)   ),
        .we_i       ( dec_we                                       ),
        .word_idx_i ( dec_word_idx                                 ),
        .wdata_i    ( dec_wdata                                    ),
        .strb_i     ( dec_strb                                     ),
        .en_i       ( pipe_advance                                 ),
        .rdata_o    ( ram_rdata                                    )
    );

    soc_resp_mux i_resp_mux (
        .clk            ( clk          ),
        .ndmreset_n     ( ndmreset_n   ),
        .sel_q_i        ( sel_q        ),
        .err_q_i        ( err_q        ),
        .stage_valid_i  ( valid_q      ),
        .we_q_i         ( we_q         ),
        .rom_rdata_i    ( rom_rdata    ),
        .clint_rdata_i  ( clint_rdata  ),
        .ram_rdata_i    ( ram_rdata    ),
        .rsp_ready_i    ( rsp_ready_i  ),
        .rsp_valid_o    ( rsp_valid_o  ),
        .rsp_rdata_o    ( rsp_rdata_o  ),
        .rsp_err_o      ( rsp_err_o    ),
        .pipe_advance_o ( pipe_advance )
    );

endmodule

//--- bench/soc_bus_checker.sv
// Bound assertions on response hold, reset state and request ready
`timescale 1ns/1ps

module soc_bus_checker (
    input logic           clk,
    input logic           ndmreset_n,
    input logic           req_ready_i,
    input logic           rsp_valid_i,
    input logic           rsp_ready_i,
    input soc_pkg::data_t rsp_rdata_i,
    input logic           rsp_err_i
);
    // A stalled response holds all its fields
    rsp_hold_a: assert property (@(posedge clk) disable iff (!ndmreset_n)
        (rsp_valid_i && !rsp_ready_i) |=>
            (rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i)))
        else $error("Response changed or vanished while stalled");

    rsp_reset_a: assert property (@(posedge clk)
        !ndmreset_n |-> !rsp_valid_i)
        else $error("Response valid high during reset");

    // Ready drops only for a held response
    req_ready_a: assert property (@(posedge clk) disable iff (!ndmreset_n)
        (!req_ready_i) == (rsp_valid_i && !rsp_ready_i))
        else $error("Request ready does not match response stall");

endmodule

bind soc_bus_top soc_bus_checker u_bus_checker (
    .clk         ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_ready_i ( req_ready_o ),
    .rsp_valid_i ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_i ( rsp_rdata_o ),
    .rsp_err_i   ( rsp_err_o   )
);

//--- bench/tb_soc_bus.sv
// Directed testbench for the bus top level: ROM, RAM, CLINT,
// unmapped accesses and response back-pressure
`timescale 1ns/1ps

module tb_soc_bus;
    localparam int RamWords = 4096;
    localparam int Timeout  = 200;     // Cycles allowed per wait loop

    logic           clk;
    logic           ndmreset_n;
    logic           req_valid;
    logic           req_ready;
    logic           req_we;
    soc_pkg::addr_t req_addr;
    soc_pkg::data_t req_wdata;
    soc_pkg::strb_t req_strb;
    logic           rsp_valid;
    logic           rsp_ready;
    soc_pkg::data_t rsp_rdata;
    logic           rsp_err;
    logic           timer_irq;
    logic           ipi;

    soc_pkg::data_t rom_model [soc_pkg::RomWords];
    soc_pkg::data_t ram_model [8];     // Expected RAM words
    soc_pkg::addr_t ram_addr  [8];
    logic [31:0]    lcg_state;
    int             errors;
    int             timeouts;

    soc_bus_top #(
        .RamWords ( RamWords )
    ) dut_i (
        .clk         ( clk        ),
        .ndmreset_n  ( ndmreset_n ),
        .req_valid_i ( req_valid  ),
        .req_ready_o ( req_ready  ),
        .req_we_i    ( req_we     ),
        .req_addr_i  ( req_addr   ),
        .req_wdata_i ( req_wdata  ),
        .req_strb_i  ( req_strb   ),
        .rsp_valid_o ( rsp_valid  ),
        .rsp_ready_i ( rsp_ready  ),
        .rsp_rdata_o ( rsp_rdata  ),
        .rsp_err_o   ( rsp_err    ),
        .timer_irq_o ( timer_irq  ),
        .ipi_o       ( ipi        )
    );

    always #2 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic soc_pkg::data_t merge_bytes(soc_pkg::data_t old_w,
                                                   soc_pkg::data_t new_w,
                                                   soc_pkg::strb_t strb);
        soc_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(string what);
        timeouts++;
        $display("Timeout after %0d cycles while waiting for %s", Timeout, what);
        finish_run();
    endtask

    task automatic check_word(string what, soc_pkg::data_t got, soc_pkg::data_t exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Drives one request and returns at its transfer edge
    task automatic issue_req(logic we, soc_pkg::addr_t addr, soc_pkg::data_t wdata,
                             soc_pkg::strb_t strb);
        int n;
        n = 0;
        @(negedge clk);
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        req_strb  = strb;
        #1;
        while (!req_ready) begin
            n++;
            if (n > Timeout) begin
                stop_on_timeout("request ready");
            end
            @(negedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic collect_rsp(output soc_pkg::data_t rdata, output logic err);
        int n;
        n = 0;
        @(negedge clk);
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        #1;
        while (!rsp_valid) begin
            n++;
            if (n > Timeout) begin
                stop_on_timeout("response valid");
            end
            @(negedge clk);
            #1;
        end
        rdata = rsp_rdata;               // Taken at the next rising edge
        err   = rsp_err;
    endtask

    task automatic check_access(string what, logic we, soc_pkg::addr_t addr,
                                soc_pkg::data_t wdata, soc_pkg::strb_t strb,
                                soc_pkg::data_t exp_data, logic exp_err);
        soc_pkg::data_t rdata;
        logic           err;
        issue_req(we, addr, wdata, strb);
        collect_rsp(rdata, err);
        check_word($sformatf("%s at %h data", what, addr), rdata, exp_data);
        check_word($sformatf("%s at %h error", what, addr), 32'(err), 32'(exp_err));
    endtask

    task automatic read_mtime(output soc_pkg::timer_t t);
        soc_pkg::data_t lo;
        soc_pkg::data_t hi;
        logic           err;
        issue_req(1'b0, soc_pkg::ClintBase + soc_pkg::MtimeLoOffset, '0, '0);
        collect_rsp(lo, err);
        check_word("mtime lo read error", 32'(err), '0);
        issue_req(1'b0, soc_pkg::ClintBase + soc_pkg::MtimeHiOffset, '0, '0);
        collect_rsp(hi, err);
        check_word("mtime hi read error", 32'(err), '0);
        t = {hi, lo};
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_after_reset();
        @(negedge clk);
        #1;
        check_word("rsp_valid after reset", 32'(rsp_valid), '0);
        check_word("timer_irq after reset", 32'(timer_irq), '0);
        check_word("ipi after reset", 32'(ipi), '0);
        check_word("req_ready after reset", 32'(req_ready), 32'd1);
    endtask

    task automatic test_rom();
        for (int i = 0; i < soc_pkg::RomWords; i++) begin
            check_access("ROM read", 1'b0, soc_pkg::RomBase + 32'(4 * i), '0, '0,
                         rom_model[i], 1'b0);
        end
        check_access("ROM write", 1'b1, soc_pkg::RomBase + 32'h8, 32'hdead_beef, 4'hf,
                     '0, 1'b1);
    endtask

    task automatic test_ram();
        soc_pkg::data_t wdata;
        soc_pkg::strb_t strb;
        int             idx;
        for (int i = 0; i < 8; i++) begin
            idx          = (i == 7) ? RamWords - 1 : i * 613;   // Last word included
            ram_addr[i]  = soc_pkg::RamBase + 32'(4 * idx);
            ram_model[i] = next_rand();
            check_access("RAM fill", 1'b1, ram_addr[i], ram_model[i], 4'hf, '0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            wdata = next_rand();
            strb  = soc_pkg::strb_t'(next_rand() >> 28);     // Upper LCG bits
            check_access("RAM strobe write", 1'b1, ram_addr[i], wdata, strb, '0, 1'b0);
            ram_model[i] = merge_bytes(ram_model[i], wdata, strb);
        end
        for (int i = 0; i < 8; i++) begin
            check_access("RAM read", 1'b0, ram_addr[i], '0, '0, ram_model[i], 1'b0);
        end
    endtask

    task automatic test_unmapped();
        soc_pkg::addr_t bad [4];
        bad = '{32'h0001_0040, 32'h0200_c000, soc_pkg::RamBase + 32'(RamWords * 4),
                32'h4000_0000};
        for (int i = 0; i < 4; i++) begin
            check_access("Unmapped read", 1'b0, bad[i], '0, '0, '0, 1'b1);
            check_access("Unmapped write", 1'b1, bad[i], 32'h1234_5678, 4'hf, '0, 1'b1);
        end
    endtask

    task automatic test_clint();
        soc_pkg::timer_t t0;
        soc_pkg::timer_t t1;
        soc_pkg::timer_t cmp;
        int              n;
        check_access("msip set", 1'b1, soc_pkg::ClintBase, 32'd1, 4'hf, '0, 1'b0);
        check_word("ipi after msip set", 32'(ipi), 32'd1);
        check_access("msip read", 1'b0, soc_pkg::ClintBase, '0, '0, 32'd1, 1'b0);
        check_access("msip clear", 1'b1, soc_pkg::ClintBase, '0, 4'hf, '0, 1'b0);
        check_word("ipi after msip clear", 32'(ipi), '0);
        read_mtime(t0);
        read_mtime(t1);
        assert (t1 > t0) else begin
            errors++;
            $display("[FAIL] %0t ns: mtime did not increase, %0d then %0d", $time, t0, t1);
        end
        cmp = t1 + 64'd40;
        check_access("mtimecmp lo write", 1'b1,
                     soc_pkg::ClintBase + soc_pkg::MtimecmpLoOffset, cmp[31:0], 4'hf, '0, 1'b0);
        check_access("mtimecmp hi write", 1'b1,
                     soc_pkg::ClintBase + soc_pkg::MtimecmpHiOffset, cmp[63:32], 4'hf, '0, 1'b0);
        check_word("timer_irq right after mtimecmp write", 32'(timer_irq), '0);
        n = 0;
        while (!timer_irq) begin
            n++;
            if (n > Timeout) begin
                stop_on_timeout("timer interrupt");
            end
            @(negedge clk);
        end
        check_access("mtimecmp hi clear", 1'b1,
                     soc_pkg::ClintBase + soc_pkg::MtimecmpHiOffset, '1, 4'hf, '0, 1'b0);
        check_access("mtimecmp lo clear", 1'b1,
                     soc_pkg::ClintBase + soc_pkg::MtimecmpLoOffset, '1, 4'hf, '0, 1'b0);
        check_word("timer_irq after mtimecmp clear", 32'(timer_irq), '0);
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        int          taken;
        int          n;
        @(negedge clk);
        rsp_ready = 1'b0;
        for (int k = 0; k < 3; k++) begin
            issue_req(1'b0, ram_addr[k], '0, '0);
        end
        @(negedge clk);
        req_valid = 1'b0;
        #1;
        check_word("req_ready while stalled", 32'(req_ready), '0);
        check_word("rsp_valid while stalled", 32'(rsp_valid), 32'd1);
        repeat (3) @(negedge clk);       // Hold the stall a little longer
        taken = 0;
        n     = 0;
        while (taken < 3) begin
            n++;
            if (n > Timeout) begin
                stop_on_timeout("stalled responses");
            end
            @(negedge clk);
            rnd       = next_rand();
            rsp_ready = rnd[31];         // Random gaps
            #1;
            if (rsp_valid && rsp_ready) begin
                check_word($sformatf("Stalled read %0d data", taken), rsp_rdata,
                           ram_model[taken]);
                check_word($sformatf("Stalled read %0d error", taken), 32'(rsp_err), '0);
                taken++;
            end
        end
        @(negedge clk);
        rsp_ready = 1'b1;
        #1;
        check_word("Extra response after drain", 32'(rsp_valid), '0);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk        = 1'b0;
        ndmreset_n = 1'b1;
        req_valid  = 1'b0;
        req_we     = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_strb   = '0;
        rsp_ready  = 1'b1;
        lcg_state  = 32'd36806;
        errors     = 0;
        timeouts   = 0;
        $readmemh("hw/boot_rom.hex", rom_model);
        #1 ndmreset_n = 1'b0;            // Clean falling edge for the async reset
        repeat (10) @(posedge clk);
        @(negedge clk);
        ndmreset_n = 1'b1;
        test_after_reset();
        test_rom();
        test_ram();
        test_unmapped();
        test_clint();
        test_backpressure();
        finish_run();
    end

endmodule

//--- soc_bus.f
hw/soc_pkg.sv
hw/soc_req_decode.sv
hw/boot_rom.sv
hw/clint_timer.sv
hw/scratch_ram.sv
hw/soc_resp_mux.sv
hw/soc_bus_top.sv
bench/soc_bus_checker.sv
bench/tb_soc_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build the bus testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
    -f soc_bus.f -o sim_soc_bus
./obj_dir/sim_soc_bus > sim.log 2>&1
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

//--- hw/boot_rom.hex
// Boot ROM image, one 32-bit hex word per line, word 0 first
f1402573
00000597
02058593
0005a283
00028067
10500073
ffdff06f
00000013
0badc0de
13572468
2468ace0
5a5aa5a5
00010000
02000000
80000000
fedcba98
